// ==== source/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   // datapath and address width, one word
   localparam int grlen = 32;

   // bytes per word, also the write strobe width
   localparam int word_bytes = 4;

   // register number width
   localparam int reg_addr_w = 5;

   // accesses that can wait for data at once
   localparam int queue_depth = 4;

   // queue pointer and occupancy widths
   localparam int queue_ptr_w = $clog2(queue_depth);
   localparam int queue_cnt_w = $clog2(queue_depth + 1);

   // operations accepted from the execute stage
   typedef enum logic [3:0] {
      op_ld_b  = 4'h0,
      op_ld_bu = 4'h1,
      op_ld_h  = 4'h2,
      op_ld_hu = 4'h3,
      op_ld_w  = 4'h4,
      op_st_b  = 4'h5,
      op_st_h  = 4'h6,
      op_st_w  = 4'h7,
      op_ll_w  = 4'h8,
      op_sc_w  = 4'h9,
      op_preld = 4'ha
   } lsu_op_e;

   // access width
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_e;

   // what the result side needs of one accepted access
   typedef struct packed {
      access_size_e                size;
      logic                        zero_ext;
      // loads, ll and preld
      logic                        is_load;
      logic [1:0]                  byte_offset;
      logic [reg_addr_w-1:0]       rd;
      logic                        wen;
   } pending_entry_t;

endpackage

`default_nettype wire

// ==== source/lsu_request.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_request (
   input  logic                         valid,
   input  lsu_pkg::lsu_op_e             lsu_op,
   input  logic [lsu_pkg::grlen-1:0]    base,
   input  logic [lsu_pkg::grlen-1:0]    offset,
   input  logic [lsu_pkg::grlen-1:0]    wdata,
   input  logic [lsu_pkg::reg_addr_w-1:0] ecl_lsu_rd_e,
   input  logic                         ecl_lsu_wen_e,
   input  logic                         full,
   input  logic                         data_addr_ok,
   output logic                         data_req,
   output logic                         data_wr,
   output logic                         data_prefetch,
   output logic                         data_ll,
   output logic                         data_sc,
   output logic [lsu_pkg::grlen-1:0]    data_addr,
   output logic [lsu_pkg::grlen-1:0]    data_wdata,
   output logic [lsu_pkg::word_bytes-1:0] data_wstrb,
   output logic                         lsu_addr_finish,
   output logic                         push,
   output lsu_pkg::pending_entry_t      push_entry
);

   lsu_pkg::access_size_e     size;
   logic                      zero_ext;
   logic                      is_load;
   logic                      is_store;
   logic [lsu_pkg::grlen-1:0] addr;
   logic                      accept;

   // one decode of the operation
   always_comb begin
      size = lsu_pkg::size_word;
      zero_ext = 1'b0;
      is_load = 1'b0;
      is_store = 1'b0;
      case (lsu_op)
         lsu_pkg::op_ld_b: begin
            size = lsu_pkg::size_byte;
            is_load = 1'b1;
         end
         lsu_pkg::op_ld_bu: begin
            size = lsu_pkg::size_byte;
            zero_ext = 1'b1;
            is_load = 1'b1;
         end
         lsu_pkg::op_ld_h: begin
            size = lsu_pkg::size_half;
            is_load = 1'b1;
         end
         lsu_pkg::op_ld_hu: begin
            size = lsu_pkg::size_half;
            zero_ext = 1'b1;
            is_load = 1'b1;
         end
         lsu_pkg::op_ld_w, lsu_pkg::op_ll_w: is_load = 1'b1;
         lsu_pkg::op_st_b: begin
            size = lsu_pkg::size_byte;
            is_store = 1'b1;
         end
         lsu_pkg::op_st_h: begin
            size = lsu_pkg::size_half;
            is_store = 1'b1;
         end
         lsu_pkg::op_st_w, lsu_pkg::op_sc_w: is_store = 1'b1;
         // prefetch behaves as a byte load
         lsu_pkg::op_preld: begin
            size = lsu_pkg::size_byte;
            is_load = 1'b1;
         end
         default: ;
      endcase
   end

   assign addr = base + offset;

   // strobes and lane replication, zero for anything but a write
   always_comb begin
      data_wstrb = '0;
      data_wdata = '0;
      if (is_store) begin
         case (size)
            lsu_pkg::size_byte: begin
               data_wstrb = 4'b0001 << addr[1:0];
               data_wdata = {4{wdata[7:0]}};
            end
            lsu_pkg::size_half: begin
               data_wstrb = 4'b0011 << addr[1:0];
               data_wdata = {2{wdata[15:0]}};
            end
            default: begin
               data_wstrb = 4'b1111;
               data_wdata = wdata;
            end
         endcase
      end
   end

   assign data_req      = valid && !full;
   assign data_addr     = addr;
   assign data_wr       = is_store;
   assign data_prefetch = lsu_op == lsu_pkg::op_preld;
   assign data_ll       = lsu_op == lsu_pkg::op_ll_w;
   assign data_sc       = lsu_op == lsu_pkg::op_sc_w;

   // accepted in the cycle memory takes the address
   assign accept          = data_req && data_addr_ok;
   assign lsu_addr_finish = accept;
   assign push            = accept;

   assign push_entry.size        = size;
   assign push_entry.zero_ext    = zero_ext;
   assign push_entry.is_load     = is_load;
   assign push_entry.byte_offset = addr[1:0];
   assign push_entry.rd          = ecl_lsu_rd_e;
   assign push_entry.wen         = ecl_lsu_wen_e;

endmodule

`default_nettype wire

// ==== source/lsu_pending_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_pending_queue (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    push,
   input  lsu_pkg::pending_entry_t push_entry,
   input  logic                    pop,
   output logic                    full,
   output logic                    not_empty,
   output lsu_pkg::pending_entry_t head_entry
);

   lsu_pkg::pending_entry_t             entries [lsu_pkg::queue_depth];
   logic [lsu_pkg::queue_ptr_w-1:0]     rd_ptr;
   logic [lsu_pkg::queue_ptr_w-1:0]     wr_ptr;
   logic [lsu_pkg::queue_cnt_w-1:0]     count;
   logic                                do_push;
   logic                                do_pop;

   assign full      = count == lsu_pkg::queue_cnt_w'(lsu_pkg::queue_depth);
   assign not_empty = count != '0;

   // a full queue still takes a push when the head leaves in the same cycle
   assign do_pop  = pop && not_empty;
   assign do_push = push && (!full || do_pop);

   // payload storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         entries[wr_ptr] <= push_entry;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            if (wr_ptr == lsu_pkg::queue_ptr_w'(lsu_pkg::queue_depth - 1)) begin
               wr_ptr <= '0;
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (do_pop) begin
            if (rd_ptr == lsu_pkg::queue_ptr_w'(lsu_pkg::queue_depth - 1)) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   // oldest access, read straight from storage
   assign head_entry = entries[rd_ptr];

endmodule

`default_nettype wire

// ==== source/lsu_load_align.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_load_align (
   input  lsu_pkg::pending_entry_t          head_entry,
   input  logic [lsu_pkg::grlen-1:0]        data_rdata,
   input  logic                             data_scsucceed,
   output logic [lsu_pkg::grlen-1:0]        read_result_m,
   output logic [lsu_pkg::reg_addr_w-1:0]   lsu_ecl_rd_m,
   output logic                             lsu_ecl_wen_m
);

   logic [lsu_pkg::grlen-1:0] lane_shifted;
   logic [7:0]                lane_byte;
   logic [15:0]               lane_half;
   logic                      byte_sign;
   logic                      half_sign;

   // move the addressed lane down to bit 0
   assign lane_shifted = data_rdata >> {head_entry.byte_offset, 3'b000};
   assign lane_byte    = lane_shifted[7:0];
   assign lane_half    = lane_shifted[15:0];

   // sign bit, or zero for unsigned loads
   assign byte_sign = lane_byte[7] && !head_entry.zero_ext;
   assign half_sign = lane_half[15] && !head_entry.zero_ext;

   always_comb begin
      if (head_entry.is_load) begin
         case (head_entry.size)
            lsu_pkg::size_byte: begin
               read_result_m = {{(lsu_pkg::grlen - 8){byte_sign}}, lane_byte};
            end
            lsu_pkg::size_half: begin
               read_result_m = {{(lsu_pkg::grlen - 16){half_sign}}, lane_half};
            end
            default: begin
               read_result_m = data_rdata;
            end
         endcase
      end else begin
         // stores and sc report only the sc outcome
         read_result_m = {{(lsu_pkg::grlen - 1){1'b0}}, data_scsucceed};
      end
   end

   assign lsu_ecl_rd_m  = head_entry.rd;
   assign lsu_ecl_wen_m = head_entry.wen;

endmodule

`default_nettype wire

// ==== source/lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
   input  logic                             clk,
   input  logic                             reset,

   // execute stage
   input  logic                             valid,
   input  lsu_pkg::lsu_op_e                 lsu_op,
   input  logic [lsu_pkg::grlen-1:0]        base,
   input  logic [lsu_pkg::grlen-1:0]        offset,
   input  logic [lsu_pkg::grlen-1:0]        wdata,
   input  logic [lsu_pkg::reg_addr_w-1:0]   ecl_lsu_rd_e,
   input  logic                             ecl_lsu_wen_e,

   // memory request side
   output logic                             data_req,
   output logic                             data_wr,
   output logic                             data_prefetch,
   output logic                             data_ll,
   output logic                             data_sc,
   output logic                             data_recv,
   output logic [lsu_pkg::grlen-1:0]        data_addr,
   output logic [lsu_pkg::grlen-1:0]        data_wdata,
   output logic [lsu_pkg::word_bytes-1:0]   data_wstrb,
   input  logic                             data_addr_ok,

   // memory return side
   input  logic                             data_data_ok,
   input  logic                             data_scsucceed,
   input  logic [lsu_pkg::grlen-1:0]        data_rdata,

   // to the result stage
   output logic                             lsu_addr_finish,
   output logic                             lsu_rdata_valid_m,
   output logic                             lsu_ecl_wen_m,
   output logic [lsu_pkg::grlen-1:0]        read_result_m,
   output logic [lsu_pkg::reg_addr_w-1:0]   lsu_ecl_rd_m
);

   logic                    full;
   logic                    push;
   lsu_pkg::pending_entry_t push_entry;
   lsu_pkg::pending_entry_t head_entry;

   lsu_request u_request (
      .valid           (valid),
      .lsu_op          (lsu_op),
      .base            (base),
      .offset          (offset),
      .wdata           (wdata),
      .ecl_lsu_rd_e    (ecl_lsu_rd_e),
      .ecl_lsu_wen_e   (ecl_lsu_wen_e),
      .full            (full),
      .data_addr_ok    (data_addr_ok),
      .data_req        (data_req),
      .data_wr         (data_wr),
      .data_prefetch   (data_prefetch),
      .data_ll         (data_ll),
      .data_sc         (data_sc),
      .data_addr       (data_addr),
      .data_wdata      (data_wdata),
      .data_wstrb      (data_wstrb),
      .lsu_addr_finish (lsu_addr_finish),
      .push            (push),
      .push_entry      (push_entry)
   );

   // every data_data_ok retires the oldest access
   lsu_pending_queue u_queue (
      .clk        (clk),
      .reset      (reset),
      .push       (push),
      .push_entry (push_entry),
      .pop        (data_data_ok),
      .full       (full),
      .not_empty  (data_recv),
      .head_entry (head_entry)
   );

   lsu_load_align u_align (
      .head_entry     (head_entry),
      .data_rdata     (data_rdata),
      .data_scsucceed (data_scsucceed),
      .read_result_m  (read_result_m),
      .lsu_ecl_rd_m   (lsu_ecl_rd_m),
      .lsu_ecl_wen_m  (lsu_ecl_wen_m)
   );

   assign lsu_rdata_valid_m = data_data_ok;

endmodule

`default_nettype wire

// ==== tests/lsu_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_queue_props (
   input logic                              clk,
   input logic                              reset,
   input logic                              push,
   input logic                              pop,
   input logic                              full,
   input logic                              not_empty,
   input logic [lsu_pkg::queue_cnt_w-1:0]   count,
   input logic [lsu_pkg::queue_ptr_w-1:0]   rd_ptr,
   input logic [lsu_pkg::queue_ptr_w-1:0]   wr_ptr
);

   // a full queue only takes a push alongside a pop
   push_into_full: assert property (@(posedge clk) disable iff (reset)
      full && push |-> pop)
      else $error("push into a full pending queue without a pop");

   pop_from_empty: assert property (@(posedge clk) disable iff (reset)
      !not_empty |-> !pop)
      else $error("pop from an empty pending queue");

   // pointers meet again once every slot is taken
   count_at_depth: assert property (@(posedge clk) disable iff (reset)
      count == lsu_pkg::queue_cnt_w'(lsu_pkg::queue_depth) |-> wr_ptr == rd_ptr)
      else $error("pending queue at depth with read and write pointers apart");

endmodule

bind lsu_pending_queue lsu_queue_props u_props (
   .clk       (clk),
   .reset     (reset),
   .push      (push),
   .pop       (pop),
   .full      (full),
   .not_empty (not_empty),
   .count     (count),
   .rd_ptr    (rd_ptr),
   .wr_ptr    (wr_ptr)
);

`default_nettype wire

// ==== tests/lsu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;

   localparam int n_rows = 20;
   // from this row on, returns are held until the queue has been full a while
   localparam int stall_row = 8;

   logic                                clk;
   logic                                reset;
   logic                                valid;
   lsu_pkg::lsu_op_e                    lsu_op;
   logic [lsu_pkg::grlen-1:0]           base;
   logic [lsu_pkg::grlen-1:0]           offset;
   logic [lsu_pkg::grlen-1:0]           wdata;
   logic [lsu_pkg::reg_addr_w-1:0]      ecl_lsu_rd_e;
   logic                                ecl_lsu_wen_e;
   logic                                data_req, data_wr, data_prefetch;
   logic                                data_ll, data_sc, data_recv;
   logic [lsu_pkg::grlen-1:0]           data_addr, data_wdata, data_rdata;
   logic [lsu_pkg::word_bytes-1:0]      data_wstrb;
   logic                                data_addr_ok, data_data_ok, data_scsucceed;
   logic                                lsu_addr_finish, lsu_rdata_valid_m, lsu_ecl_wen_m;
   logic [lsu_pkg::grlen-1:0]           read_result_m;
   logic [lsu_pkg::reg_addr_w-1:0]      lsu_ecl_rd_m;

   // stimulus table, one access per row
   lsu_pkg::lsu_op_e                    tbl_op     [n_rows];
   logic [31:0]                         tbl_base   [n_rows];
   logic [31:0]                         tbl_offset [n_rows];
   logic [31:0]                         tbl_wdata  [n_rows];
   logic [4:0]                          tbl_rd     [n_rows];
   logic                                tbl_wen    [n_rows];
   logic [31:0]                         tbl_mem    [n_rows];
   logic                                tbl_sc     [n_rows];
   logic                                row_bad    [n_rows];

   int                                  errors;
   int                                  returned;
   int                                  rows_added;
   // accepted rows still waiting for data, oldest first
   int                                  inflight [$];
   logic                                stall_returns;

   lsu_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check(input int row, input string name, input logic [31:0] exp,
                        input logic [31:0] act);
      if (exp !== act) begin
         $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
         errors++;
         if (row >= 0) begin
            row_bad[row] = 1'b1;
         end
      end
   endtask

   task automatic add_row(input lsu_pkg::lsu_op_e op, input logic [31:0] b,
                          input logic [31:0] off, input logic [31:0] wd, input logic [4:0] rd,
                          input logic wen, input logic [31:0] mem, input logic sc);
      tbl_op[rows_added] = op;
      tbl_base[rows_added] = b;
      tbl_offset[rows_added] = off;
      tbl_wdata[rows_added] = wd;
      tbl_rd[rows_added] = rd;
      tbl_wen[rows_added] = wen;
      tbl_mem[rows_added] = mem;
      tbl_sc[rows_added] = sc;
      row_bad[rows_added] = 1'b0;
      rows_added++;
   endtask

   task automatic load_table();
      rows_added = 0;
      add_row(lsu_pkg::op_st_b, 32'h1000, 32'h0, 32'h0000_00a5, 5'd1, 1'b0, 32'hffff_ffff, 1'b0);
      add_row(lsu_pkg::op_st_b, 32'h1000, 32'h1, 32'h0000_775c, 5'd2, 1'b0, 32'hffff_ffff, 1'b1);
      add_row(lsu_pkg::op_st_b, 32'h1001, 32'h2, 32'h0000_003c, 5'd3, 1'b0, 32'h0, 1'b0);
      add_row(lsu_pkg::op_st_h, 32'h2000, 32'h0, 32'h0000_beef, 5'd4, 1'b0, 32'h0, 1'b0);
      add_row(lsu_pkg::op_st_h, 32'h2000, 32'h2, 32'h9999_1234, 5'd5, 1'b0, 32'h0, 1'b0);
      add_row(lsu_pkg::op_st_w, 32'h3000, 32'h4, 32'hdead_beef, 5'd6, 1'b0, 32'hffff_ffff, 1'b1);
      add_row(lsu_pkg::op_ld_b, 32'h4000, 32'h0, 32'h0, 5'd7, 1'b1, 32'h1234_5680, 1'b0);
      add_row(lsu_pkg::op_ld_b, 32'h4000, 32'h3, 32'h0, 5'd8, 1'b1, 32'h7f00_0000, 1'b0);
      add_row(lsu_pkg::op_ld_bu, 32'h4001, 32'h1, 32'h0, 5'd9, 1'b1, 32'h00c3_0000, 1'b0);
      add_row(lsu_pkg::op_ld_h, 32'h5000, 32'h2, 32'h0, 5'd10, 1'b1, 32'h8001_0000, 1'b0);
      add_row(lsu_pkg::op_ld_h, 32'h5000, 32'h0, 32'h0, 5'd11, 1'b1, 32'h0000_7ffe, 1'b0);
      add_row(lsu_pkg::op_ld_hu, 32'h5002, 32'h0, 32'h0, 5'd12, 1'b1, 32'hf00d_0000, 1'b0);
      add_row(lsu_pkg::op_ld_hu, 32'h5000, 32'h0, 32'h0, 5'd13, 1'b1, 32'h0000_abcd, 1'b0);
      add_row(lsu_pkg::op_ld_w, 32'h6000, 32'h8, 32'h0, 5'd14, 1'b1, 32'hcafe_f00d, 1'b0);
      add_row(lsu_pkg::op_ll_w, 32'h7000, 32'h0, 32'h0, 5'd15, 1'b1, 32'h1357_9bdf, 1'b0);
      add_row(lsu_pkg::op_sc_w, 32'h7000, 32'h0, 32'h2468_ace0, 5'd16, 1'b1, 32'hffff_ffff, 1'b1);
      add_row(lsu_pkg::op_sc_w, 32'h7000, 32'h0, 32'h0000_0001, 5'd17, 1'b1, 32'h0, 1'b0);
      add_row(lsu_pkg::op_preld, 32'h8000, 32'h40, 32'h0, 5'd0, 1'b0, 32'h5555_aaaa, 1'b0);
      add_row(lsu_pkg::op_ld_bu, 32'h4000, 32'h1, 32'h0, 5'd18, 1'b1, 32'h0011_a233, 1'b0);
      add_row(lsu_pkg::op_st_w, 32'h9010, 32'hffff_fff0, 32'h0bad_f00d, 5'd19, 1'b0, 32'h0, 1'b0);
   endtask

   function automatic logic [31:0] row_addr(input int i);
      return tbl_base[i] + tbl_offset[i];
   endfunction

   // strobe and lane copies for a write
   task automatic expected_write(input int i, output logic [3:0] strobe,
                                 output logic [31:0] data);
      logic [31:0] a;
      a = row_addr(i);
      case (tbl_op[i])
         lsu_pkg::op_st_b: begin
            strobe = 4'b0001 << a[1:0];
            data = {4{tbl_wdata[i][7:0]}};
         end
         lsu_pkg::op_st_h: begin
            strobe = 4'b0011 << a[1:0];
            data = {2{tbl_wdata[i][15:0]}};
         end
         default: begin
            strobe = 4'b1111;
            data = tbl_wdata[i];
         end
      endcase
   endtask

   function automatic logic [31:0] expected_result(input int i);
      logic [31:0] a;
      logic [31:0] lane;
      a = row_addr(i);
      lane = tbl_mem[i] >> (8 * a[1:0]);
      case (tbl_op[i])
         lsu_pkg::op_ld_b:  return {{24{lane[7]}}, lane[7:0]};
         lsu_pkg::op_ld_bu: return {24'h0, lane[7:0]};
         lsu_pkg::op_ld_h:  return {{16{lane[15]}}, lane[15:0]};
         lsu_pkg::op_ld_hu: return {16'h0, lane[15:0]};
         lsu_pkg::op_ld_w, lsu_pkg::op_ll_w: return tbl_mem[i];
         // stores and sc only carry the sc outcome
         default: return {31'h0, tbl_sc[i]};
      endcase
   endfunction

   // memory return side, in order, 1 to 6 cycles per access
   initial begin
      int idx;
      int ret_wait;
      data_data_ok = 1'b0;
      data_rdata = '0;
      data_scsucceed = 1'b0;
      ret_wait = 0;
      forever begin
         @(negedge clk);
         data_data_ok = 1'b0;
         if (inflight.size() != 0 && !stall_returns) begin
            if (ret_wait > 0) begin
               ret_wait--;
            end else begin
               idx = inflight.pop_front();
               data_data_ok = 1'b1;
               data_rdata = tbl_mem[idx];
               data_scsucceed = tbl_sc[idx];
               @(posedge clk);
               check(idx, "data_recv", 1, data_recv);
               check(idx, "lsu_rdata_valid_m", 1, lsu_rdata_valid_m);
               check(idx, "lsu_ecl_rd_m", tbl_rd[idx], lsu_ecl_rd_m);
               check(idx, "lsu_ecl_wen_m", tbl_wen[idx], lsu_ecl_wen_m);
               // a prefetch returns nothing the core uses
               if (tbl_op[idx] != lsu_pkg::op_preld) begin
                  check(idx, "read_result_m", expected_result(idx), read_result_m);
               end
               $display("test %0d %s: %s", idx, tbl_op[idx].name(),
                        row_bad[idx] ? "mismatch" : "ok");
               returned++;
               ret_wait = $urandom % 6;
            end
         end
      end
   end

   initial begin
      repeat (n_rows * 20 + 16) @(posedge clk);
      $display("timeout: the accesses did not all complete in time");
      $display("SIMULATION FAILED");
      $finish;
   end

   // request side and memory address acceptance
   initial begin
      logic [3:0]  exp_strobe;
      logic [31:0] exp_wdata;
      logic        exp_req;
      logic        is_write;
      logic        accepted;
      int          addr_delay;
      int          full_cycles;
      int          bad_rows;
      void'($urandom(32'hfdc6_9986));
      errors = 0;
      returned = 0;
      full_cycles = 0;
      bad_rows = 0;
      stall_returns = 1'b0;
      reset = 1'b1;
      valid = 1'b0;
      lsu_op = lsu_pkg::op_ld_w;
      base = '0;
      offset = '0;
      wdata = '0;
      ecl_lsu_rd_e = '0;
      ecl_lsu_wen_e = 1'b0;
      data_addr_ok = 1'b0;
      load_table();
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(posedge clk);
      check(-1, "data_recv", 0, data_recv);
      check(-1, "lsu_addr_finish", 0, lsu_addr_finish);
      check(-1, "lsu_rdata_valid_m", 0, lsu_rdata_valid_m);
      check(-1, "data_req", 0, data_req);
      for (int i = 0; i < n_rows; i++) begin
         if (i == stall_row) begin
            // no request while the queue drains
            @(negedge clk);
            valid = 1'b0;
            data_addr_ok = 1'b0;
            while (inflight.size() != 0) @(posedge clk);
            stall_returns = 1'b1;
         end
         @(negedge clk);
         valid = 1'b1;
         lsu_op = tbl_op[i];
         base = tbl_base[i];
         offset = tbl_offset[i];
         wdata = tbl_wdata[i];
         ecl_lsu_rd_e = tbl_rd[i];
         ecl_lsu_wen_e = tbl_wen[i];
         addr_delay = $urandom % 4;
         accepted = 1'b0;
         while (!accepted) begin
            data_addr_ok = addr_delay == 0;
            @(posedge clk);
            exp_req = (inflight.size() + int'(data_data_ok)) < lsu_pkg::queue_depth;
            check(i, "data_req", exp_req, data_req);
            check(i, "lsu_addr_finish", exp_req && data_addr_ok, lsu_addr_finish);
            if (data_req && data_addr_ok) begin
               is_write = tbl_op[i] inside {lsu_pkg::op_st_b, lsu_pkg::op_st_h,
                                            lsu_pkg::op_st_w, lsu_pkg::op_sc_w};
               check(i, "data_addr", row_addr(i), data_addr);
               check(i, "data_wr", is_write, data_wr);
               check(i, "data_ll", tbl_op[i] == lsu_pkg::op_ll_w, data_ll);
               check(i, "data_sc", tbl_op[i] == lsu_pkg::op_sc_w, data_sc);
               check(i, "data_prefetch", tbl_op[i] == lsu_pkg::op_preld, data_prefetch);
               if (is_write) begin
                  expected_write(i, exp_strobe, exp_wdata);
                  check(i, "data_wstrb", exp_strobe, data_wstrb);
                  check(i, "data_wdata", exp_wdata, data_wdata);
               end
               inflight.push_back(i);
               accepted = 1'b1;
            end else begin
               if (addr_delay != 0) begin
                  addr_delay--;
               end
               // queue full and nothing returning
               if (stall_returns && inflight.size() == lsu_pkg::queue_depth) begin
                  full_cycles++;
                  if (full_cycles == 3) begin
                     stall_returns = 1'b0;
                  end
               end
               @(negedge clk);
            end
         end
      end
      @(negedge clk);
      valid = 1'b0;
      data_addr_ok = 1'b0;
      while (returned != n_rows) @(negedge clk);
      // every access retired, nothing left waiting
      check(-1, "data_recv", 0, data_recv);
      for (int i = 0; i < n_rows; i++) begin
         if (row_bad[i]) begin
            bad_rows++;
         end
      end
      $display("%0d tests, %0d with mismatches, %0d errors", n_rows, bad_rows, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
source/lsu_pkg.sv
source/lsu_request.sv
source/lsu_pending_queue.sv
source/lsu_load_align.sv
source/lsu_top.sv
tests/lsu_props.sv
tests/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the LSU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f flist.f -o lsu_sim \
   || { echo "verilator build failed"; exit 1; }
sim_out=$(./obj_dir/lsu_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "SIMULATION PASSED" && echo "run passed" \
   || { echo "run failed"; exit 1; }
